// File: Bender.yml
package:
  name: aes_decrypt_core

sources:
  # Package first, then the datapath leaves, then the top level.
  - src/aesPkg.sv
  - src/gfInverse.sv
  - src/aesSbox.sv
  - src/invCipherRound.sv
  - src/invKeySchedule.sv
  - src/aesDecryptCore.sv

  - target: test
    files:
      - test/aesDecryptTb.sv

// File: flist.f
src/aesPkg.sv
src/gfInverse.sv
src/aesSbox.sv
src/invCipherRound.sv
src/invKeySchedule.sv
src/aesDecryptCore.sv
test/aesDecryptTb.sv

// File: src/aesDecryptCore.sv
`timescale 1ns/100ps

module aesDecryptCore (
        input  logic             clk,
        input  logic             arstN,
        input  logic             start,
        input  aesPkg::aesBlockT cipherText,
        input  aesPkg::aesBlockT lastRoundKey,
        output aesPkg::aesBlockT plainText,
        output logic             busy,
        output logic             done
);
        import aesPkg::*;

        aesStateU stateQ;
        aesBlockT keyQ;
        roundIdxT roundQ;
        aesStateU roundOut;
        aesBlockT prevKey;
        logic     lastRound;
        logic     accept;

        assign accept    = start && !busy;
        assign lastRound = (roundQ == roundIdxT'(1));

        // Key register steps back one round key per cycle.
        invKeySchedule #(
                .Inverse (1'b0)
        ) u_invKeySchedule (
                .keyIn  (keyQ),
                .rcon   (rconOf(roundQ)),
                .keyOut (prevKey)
        );

        invCipherRound #(
                .Inverse (1'b1)
        ) u_invCipherRound (
                .stateIn  (stateQ),
                .roundKey (prevKey),
                .last     (lastRound),
                .stateOut (roundOut)
        );

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        roundQ    <= '0;
                        busy      <= 1'b0;
                        done      <= 1'b0;
                        plainText <= '0;
                end else begin
                        done <= 1'b0;
                        if (accept) begin
                                roundQ <= roundIdxT'(RoundCount);
                                busy   <= 1'b1;
                        end else if (busy) begin
                                roundQ <= roundQ - 1'b1;
                                if (lastRound) begin
                                        busy      <= 1'b0;
                                        done      <= 1'b1;
                                        plainText <= roundOut.word;
                                end
                        end
                end
        end

        // Initial round key addition happens on load.
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        stateQ.word <= '0;
                        keyQ        <= '0;
                end else if (accept) begin
                        stateQ.word <= cipherText ^ lastRoundKey;
                        keyQ        <= lastRoundKey;
                end else if (busy) begin
                        stateQ <= roundOut;
                        keyQ   <= prevKey;
                end
        end

endmodule

// File: src/aesPkg.sv
package aesPkg;

        localparam int RoundCount = 10;

        typedef logic [7:0]   aesByteT;
        typedef logic [127:0] aesBlockT;
        typedef logic [3:0]   roundIdxT;

        // Byte 0 sits in the top bits, matching FIPS-197 input order.
        typedef union packed {
                aesBlockT         word;
                aesByteT [0:15]   bytes;
        } aesStateU;

        function automatic aesByteT xtime(aesByteT a);
                return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
        endfunction

        function automatic aesByteT gfMul(aesByteT a, aesByteT b);
                aesByteT acc;
                aesByteT p;
                acc = '0;
                p = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i]) begin
                                acc = acc ^ p;
                        end
                        p = xtime(p);
                end
                return acc;
        endfunction

        // Round constant of the forward schedule for round idx.
        function automatic aesByteT rconOf(roundIdxT idx);
                aesByteT rc;
                case (idx)
                        4'd1:    rc = 8'h01;
                        4'd2:    rc = 8'h02;
                        4'd3:    rc = 8'h04;
                        4'd4:    rc = 8'h08;
                        4'd5:    rc = 8'h10;
                        4'd6:    rc = 8'h20;
                        4'd7:    rc = 8'h40;
                        4'd8:    rc = 8'h80;
                        4'd9:    rc = 8'h1b;
                        4'd10:   rc = 8'h36;
                        default: rc = 8'h00;
                endcase
                return rc;
        endfunction

endpackage

// File: src/aesSbox.sv
`timescale 1ns/100ps

module aesSbox #(
        parameter bit Inverse = 1'b0
) (
        input  aesPkg::aesByteT inByte,
        output aesPkg::aesByteT outByte
);
        import aesPkg::*;

        localparam aesByteT FwdAffineC = 8'h63;
        localparam aesByteT InvAffineC = 8'h05;

        if (Inverse) begin : genInv
                aesByteT affOut;

                // Inverse affine map first, then the field inverse.
                always_comb begin
                        for (int i = 0; i < 8; i++) begin
                                affOut[i] = inByte[(i + 2) % 8] ^ inByte[(i + 5) % 8]
                                        ^ inByte[(i + 7) % 8] ^ InvAffineC[i];
                        end
                end

                gfInverse u_gfInverse (
                        .inByte  (affOut),
                        .outByte (outByte)
                );
        end else begin : genFwd
                aesByteT invOut;

                gfInverse u_gfInverse (
                        .inByte  (inByte),
                        .outByte (invOut)
                );

                always_comb begin
                        for (int i = 0; i < 8; i++) begin
                                outByte[i] = invOut[i] ^ invOut[(i + 4) % 8]
                                        ^ invOut[(i + 5) % 8] ^ invOut[(i + 6) % 8]
                                        ^ invOut[(i + 7) % 8] ^ FwdAffineC[i];
                        end
                end
        end

endmodule

// File: src/gfInverse.sv
`timescale 1ns/100ps

module gfInverse (
        input  aesPkg::aesByteT inByte,
        output aesPkg::aesByteT outByte
);
        import aesPkg::*;

        // Inverse as x^254, since x^255 = 1 for any nonzero x.
        aesByteT pow2;
        aesByteT pow3;
        aesByteT pow6;
        aesByteT pow12;
        aesByteT pow14;
        aesByteT pow15;
        aesByteT pow30;
        aesByteT pow60;
        aesByteT pow120;
        aesByteT pow240;

        assign pow2   = gfMul(inByte, inByte);
        assign pow3   = gfMul(pow2, inByte);
        assign pow6   = gfMul(pow3, pow3);
        assign pow12  = gfMul(pow6, pow6);
        assign pow14  = gfMul(pow12, pow2);
        assign pow15  = gfMul(pow12, pow3);

        // Four squarings lift x^15 to x^240.
        assign pow30  = gfMul(pow15, pow15);
        assign pow60  = gfMul(pow30, pow30);
        assign pow120 = gfMul(pow60, pow60);
        assign pow240 = gfMul(pow120, pow120);

        // Zero falls through as zero because every product with it is zero.
        assign outByte = gfMul(pow240, pow14);

endmodule

// File: src/invCipherRound.sv
`timescale 1ns/100ps

module invCipherRound #(
        parameter bit Inverse = 1'b1
) (
        input  aesPkg::aesStateU stateIn,
        input  aesPkg::aesBlockT roundKey,
        input  logic             last,
        output aesPkg::aesStateU stateOut
);
        import aesPkg::*;

        aesStateU shifted;
        aesStateU subbed;
        aesStateU keyed;
        aesStateU mixed;
        aesByteT  sboxOut [16];

        // Byte k of the state is row k%4 of column k/4.
        // Row r rotates right by r positions.
        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                shifted.bytes[4 * c + r] = stateIn.bytes[4 * ((c + 4 - r) % 4) + r];
                        end
                end
        end

        for (genvar k = 0; k < 16; k++) begin : genSbox
                aesSbox #(
                        .Inverse (Inverse)
                ) u_aesSbox (
                        .inByte  (shifted.bytes[k]),
                        .outByte (sboxOut[k])
                );
        end

        always_comb begin
                for (int k = 0; k < 16; k++) begin
                        subbed.bytes[k] = sboxOut[k];
                end
                keyed.word = subbed.word ^ roundKey;
        end

        // Inverse mix columns, coefficients 0e 0b 0d 09 rotating per row.
        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                mixed.bytes[4 * c + r] =
                                        gfMul(8'h0e, keyed.bytes[4 * c + r])
                                        ^ gfMul(8'h0b, keyed.bytes[4 * c + (r + 1) % 4])
                                        ^ gfMul(8'h0d, keyed.bytes[4 * c + (r + 2) % 4])
                                        ^ gfMul(8'h09, keyed.bytes[4 * c + (r + 3) % 4]);
                        end
                end
        end

        // The final round has no column mixing.
        assign stateOut = last ? keyed : mixed;

endmodule

// File: src/invKeySchedule.sv
`timescale 1ns/100ps

module invKeySchedule #(
        parameter bit Inverse = 1'b0
) (
        input  aesPkg::aesBlockT keyIn,
        input  aesPkg::aesByteT  rcon,
        output aesPkg::aesBlockT keyOut
);
        import aesPkg::*;

        logic [31:0] curW  [4];
        logic [31:0] prevW [4];
        logic [31:0] rotW;
        logic [31:0] subW;
        aesByteT     subBytes [4];

        assign curW[0] = keyIn[127:96];
        assign curW[1] = keyIn[95:64];
        assign curW[2] = keyIn[63:32];
        assign curW[3] = keyIn[31:0];

        // Words 1 to 3 undo the running XOR of the forward schedule.
        assign prevW[1] = curW[0] ^ curW[1];
        assign prevW[2] = curW[1] ^ curW[2];
        assign prevW[3] = curW[2] ^ curW[3];

        // RotWord on the recovered last word.
        assign rotW = {prevW[3][23:0], prevW[3][31:24]};

        for (genvar b = 0; b < 4; b++) begin : genSbox
                aesSbox #(
                        .Inverse (Inverse)
                ) u_aesSbox (
                        .inByte  (rotW[8 * b +: 8]),
                        .outByte (subBytes[b])
                );
        end

        assign subW = {subBytes[3], subBytes[2], subBytes[1], subBytes[0]};

        assign prevW[0] = curW[0] ^ subW ^ {rcon, 24'h000000};

        assign keyOut = {prevW[0], prevW[1], prevW[2], prevW[3]};

endmodule

// File: test/aesDecryptTb.sv
`timescale 1ns/100ps

module aesDecryptTb;
        import aesPkg::*;

        localparam int ClkPeriod   = 20;
        localparam int ResetCycles = 16;
        localparam int NumTests    = 6;
        localparam int TestCycles  = 40;
        localparam int DoneTimeout = 30;
        localparam int Latency     = 10;

        // FIPS-197 C.1 vector.
        localparam aesBlockT C1Cipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        localparam aesBlockT C1Key    = 128'h13111d7fe3944a17f307a78b4d2b30c5;
        localparam aesBlockT C1Plain  = 128'h00112233445566778899aabbccddeeff;

        // FIPS-197 Appendix B vector.
        localparam aesBlockT BCipher = 128'h3925841d02dc09fbdc118597196a0b32;
        localparam aesBlockT BKey    = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;
        localparam aesBlockT BPlain  = 128'h3243f6a8885a308d313198a2e0370734;

        logic     clk;
        logic     arstN;
        logic     start;
        aesBlockT cipherText;
        aesBlockT lastRoundKey;
        aesBlockT plainText;
        logic     busy;
        logic     done;

        int errors;
        int checks;
        int cycleCount;
        int startEdge;
        int doneCount;
        int doneCycle;

        aesDecryptCore u_aesDecryptCore (
                .clk          (clk),
                .arstN        (arstN),
                .start        (start),
                .cipherText   (cipherText),
                .lastRoundKey (lastRoundKey),
                .plainText    (plainText),
                .busy         (busy),
                .done         (done)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #(ClkPeriod / 2) clk = ~clk;
                end
        end

        always @(posedge clk) begin
                cycleCount <= cycleCount + 1;
        end

        // Done pulses are counted in mid-cycle, where done is stable.
        always @(negedge clk) begin
                if (done) begin
                        doneCount <= doneCount + 1;
                        doneCycle <= cycleCount;
                end
        end

        initial begin
                #((ResetCycles + NumTests * TestCycles) * ClkPeriod);
                $display("Watchdog expired at %0t, the tests did not finish", $time);
                $display("Errors found");
                $finish;
        end

        task automatic checkValue(input logic [127:0] actual, input logic [127:0] expected,
                                  input string msg);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("Mismatch at %0t: %s, got %h, expected %h",
                                 $time, msg, actual, expected);
                end
        endtask

        // Returns in mid-cycle after the edge that samples start.
        task automatic driveStart(input aesBlockT ct, input aesBlockT key);
                @(posedge clk);
                start        <= 1'b1;
                cipherText   <= ct;
                lastRoundKey <= key;
                @(posedge clk);
                start <= 1'b0;
                @(negedge clk);
                startEdge = cycleCount;
        endtask

        task automatic waitDone(output int latency);
                bit seen;
                seen    = 1'b0;
                latency = 0;
                for (int i = 0; i < DoneTimeout && !seen; i++) begin
                        @(negedge clk);
                        if (done) begin
                                seen    = 1'b1;
                                latency = cycleCount - startEdge;
                        end else if (!busy) begin
                                errors++;
                                $display("At %0t busy was low before done arrived", $time);
                        end
                end
                if (!seen) begin
                        errors++;
                        $display("At %0t done did not arrive within %0d cycles",
                                 $time, DoneTimeout);
                end
        endtask

        task automatic decryptVector(input aesBlockT ct, input aesBlockT key,
                                     input aesBlockT expected, input string name);
                int lat;
                driveStart(ct, key);
                waitDone(lat);
                checkValue(plainText, expected, name);
        endtask

        task automatic timingAndHold();
                int lat;
                driveStart(C1Cipher, C1Key);
                checkValue(busy, 1'b1, "busy after start edge");
                waitDone(lat);
                checkValue(lat, Latency, "latency from start edge to done");
                checkValue(busy, 1'b0, "busy in done cycle");
                checkValue(plainText, C1Plain, "plainText in done cycle");
                @(negedge clk);
                checkValue(done, 1'b0, "done one cycle after rising");
                repeat (5) begin
                        @(negedge clk);
                        checkValue(plainText, C1Plain, "plainText held after done");
                end
        endtask

        // The held result is C1 here, so the B result must replace it.
        task automatic ignoreStartWhileBusy();
                int lat;
                int doneSnap;
                driveStart(BCipher, BKey);
                doneSnap = doneCount;
                repeat (3) @(posedge clk);
                start        <= 1'b1;
                cipherText   <= C1Cipher;
                lastRoundKey <= C1Key;
                @(posedge clk);
                start <= 1'b0;
                waitDone(lat);
                checkValue(lat, Latency, "latency with start while busy");
                checkValue(plainText, BPlain, "result with start while busy");
                repeat (12) @(negedge clk);
                checkValue(doneCount - doneSnap, 1, "done pulses after ignored start");
                checkValue(busy, 1'b0, "busy after ignored start");
        endtask

        task automatic backToBack();
                int lat;
                int doneSnap;
                int firstEdge;
                driveStart(C1Cipher, C1Key);
                firstEdge = startEdge;
                doneSnap  = doneCount;
                // Nine more edges reach the one before done, so start lands in the done cycle.
                repeat (9) @(posedge clk);
                driveStart(BCipher, BKey);
                checkValue(doneCount - doneSnap, 1, "first done of back-to-back pair");
                checkValue(doneCycle - firstEdge, Latency, "first latency of back-to-back pair");
                checkValue(plainText, C1Plain, "first result of back-to-back pair");
                checkValue(busy, 1'b1, "busy after start in done cycle");
                waitDone(lat);
                checkValue(lat, Latency, "second latency of back-to-back pair");
                checkValue(plainText, BPlain, "second result of back-to-back pair");
        endtask

        task automatic resetMidOperation();
                int doneSnap;
                driveStart(BCipher, BKey);
                repeat (4) @(posedge clk);
                arstN <= 1'b0;
                repeat (2) @(posedge clk);
                @(negedge clk);
                checkValue(busy, 1'b0, "busy during reset");
                checkValue(done, 1'b0, "done during reset");
                checkValue(plainText, '0, "plainText during reset");
                doneSnap = doneCount;
                @(posedge clk);
                arstN <= 1'b1;
                repeat (15) @(negedge clk);
                checkValue(doneCount - doneSnap, 0, "done pulses after reset");
                checkValue(busy, 1'b0, "busy after reset");
        endtask

        initial begin
                arstN        = 1'b0;
                start        = 1'b0;
                cipherText   = '0;
                lastRoundKey = '0;
                errors       = 0;
                checks       = 0;
                cycleCount   = 0;
                startEdge    = 0;
                doneCount    = 0;
                doneCycle    = 0;

                repeat (ResetCycles) @(posedge clk);
                arstN <= 1'b1;
                @(negedge clk);
                checkValue(busy, 1'b0, "busy after reset");
                checkValue(done, 1'b0, "done after reset");
                checkValue(plainText, '0, "plainText after reset");

                decryptVector(C1Cipher, C1Key, C1Plain, "FIPS-197 C.1 plaintext");
                decryptVector(BCipher, BKey, BPlain, "FIPS-197 Appendix B plaintext");
                timingAndHold();
                ignoreStartWhileBusy();
                backToBack();
                resetMidOperation();

                $display("%0d checks, %0d errors", checks, errors);
                if (errors == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

endmodule
